// File: files.f
+incdir+include
src/wb_pkg.sv
src/mem_stage.sv
src/mul_pipe.sv
src/div_unit.sv
src/wb_arbiter.sv
src/reg_file.sv
src/exec_backend_top.sv
verif/wb_assert.sv
verif/wb_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module wb_tb \
    -f files.f --Mdir obj_dir -o wb_sim &&
./obj_dir/wb_sim || exit 1

// File: verif/wb_cases.txt
// op  a  b  rd  pc   (all fields hex)
// op 0 alu, 1 load, 2 mul, 3 div
0 123456789abcdef0 0 01 1000
1 0000000000000040 0 02 1004
2 00000000ffffffff 0000000100000001 03 1008
3 0000000000000064 0000000000000007 04 100c
1 0000000000000013 0 06 1010
2 0123456789abcdef 0000000000000010 07 1014
0 000000000000dead 0 00 1018
1 00000000000007f8 0 08 101c
2 fedcba9876543210 0000000000000003 09 1020
0 0000000000000055 0 0a 1024
3 0000000000001234 0 05 1028
1 0000000000000805 0 0b 102c
2 0000000000000007 0000000000000009 03 1030
3 ffffffffffffffff 0000000000000010 0c 1034
1 0000000000000100 0 0d 1038
2 ffffffffffffffff ffffffffffffffff 0e 103c
0 00000000cafef00d 0 04 1040
3 8000000000000000 0000000000000003 0f 1044

// File: verif/wb_tb.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_tb
    import wb_pkg::*;
();
    localparam int MAX_CASES     = 32;
    localparam int ISSUE_TIMEOUT = 300;
    localparam int DRAIN_TIMEOUT = 600;

    logic        clk;
    logic        rst;
    logic        issue_valid;
    issue_t      issue;
    logic        mem_stall;
    logic        issue_ready;
    wb_result_t  commit;
    reg_idx_t    rf_raddr;
    xword_t      rf_rdata;

    logic [63:0] case_mem [5*MAX_CASES];
    op_kind_t    case_op [MAX_CASES];
    xword_t      case_a [MAX_CASES];
    xword_t      case_b [MAX_CASES];
    reg_idx_t    case_rd [MAX_CASES];
    pc_t         case_pc [MAX_CASES];
    xword_t      case_exp [MAX_CASES];
    logic        case_err [MAX_CASES];
    logic        case_seen [MAX_CASES];
    xword_t      shadow_regs [`WB_NREGS];   // Last value written per register
    int          n_cases;
    int          commit_total;
    logic [63:0] rng_state;

    exec_backend_top uut (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue),
        .mem_stall(mem_stall), .issue_ready(issue_ready), .commit(commit),
        .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_failure();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    function automatic logic [63:0] xorshift_step(input logic [63:0] x);
        logic [63:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    function automatic xword_t model_data(input op_kind_t op, input xword_t a,
                                          input xword_t b);
        case (op)
            OP_ALU:  return a;
            OP_LOAD: return ((a >> 3) % 64'(`WB_MEM_WORDS)) * 64'h0101_0101_0101_0101;
            OP_MUL:  return a * b;
            default: return (b == '0) ? '1 : a / b;   // RISC-V zero divisor
        endcase
    endfunction

    function automatic int find_case(input pc_t pc);
        for (int i = 0; i < n_cases; i++) begin
            if (case_pc[i] == pc) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic send_case(input int idx);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            issue.op    = case_op[idx];
            issue.a     = case_a[idx];
            issue.b     = case_b[idx];
            issue.rd    = case_rd[idx];
            issue.pc    = case_pc[idx];
            issue_valid = 1'b1;
            #1;
            accepted = issue_ready;            // Held until the next rising edge
            waited++;
            if (!accepted && waited > ISSUE_TIMEOUT) begin
                $display("Case %0d was never accepted for issue", idx);
                report_failure();
            end
        end
    endtask

    initial begin : stall_gen
        rng_state = 64'd43014;
        mem_stall = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                rng_state = xorshift_step(rng_state);
                mem_stall = (rng_state[2:0] < 3'd3);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Commit monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : commit_monitor
        int idx;
        commit_total = 0;
        for (int i = 0; i < MAX_CASES; i++) begin
            case_seen[i] = 1'b0;
        end
        for (int r = 0; r < `WB_NREGS; r++) begin
            shadow_regs[r] = '0;
        end
        forever begin
            @(negedge clk);
            #1;                                // Stall settles before sampling
            if (!rst && commit.wen) begin
                idx = find_case(commit.pc);
                if (idx < 0) begin
                    $display("A commit with pc 0x%h matches no case", commit.pc);
                    report_failure();
                end else if (case_seen[idx]) begin
                    $display("The case with pc 0x%h committed twice", commit.pc);
                    report_failure();
                end else begin
                    check_value("commit.rd", 64'(commit.rd), 64'(case_rd[idx]));
                    check_value("commit.data", commit.data, case_exp[idx]);
                    check_value("commit.error", 64'(commit.error), 64'(case_err[idx]));
                    case_seen[idx] = 1'b1;
                    commit_total++;
                    if (case_rd[idx] != '0) begin
                        shadow_regs[case_rd[idx]] = case_exp[idx];
                    end
                end
            end
        end
    end

    initial begin : main_seq
        int waited;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        rf_raddr    = '0;
        n_cases     = 0;
        for (int i = 0; i < 5*MAX_CASES; i++) begin
            case_mem[i] = '1;                  // All ones marks the end of the list
        end
        $readmemh("verif/wb_cases.txt", case_mem);
        while (n_cases < MAX_CASES && case_mem[5*n_cases] != '1) begin
            case_op[n_cases]  = op_kind_t'(case_mem[5*n_cases][1:0]);
            case_a[n_cases]   = case_mem[5*n_cases+1];
            case_b[n_cases]   = case_mem[5*n_cases+2];
            case_rd[n_cases]  = reg_idx_t'(case_mem[5*n_cases+3][4:0]);
            case_pc[n_cases]  = case_mem[5*n_cases+4];
            case_exp[n_cases] = model_data(case_op[n_cases], case_a[n_cases],
                                           case_b[n_cases]);
            case_err[n_cases] = (case_op[n_cases] == OP_LOAD)
                                && (case_a[n_cases][2:0] != 3'b000);
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("No cases were read from the cases file");
            report_failure();
        end

        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            send_case(i);
        end
        @(negedge clk);
        issue_valid = 1'b0;

        waited = 0;
        while (commit_total < n_cases) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                $display("Only %0d of %0d cases committed in time", commit_total, n_cases);
                report_failure();
            end
        end
        repeat (20) @(negedge clk);            // Room for a stray repeat commit

        for (int r = 0; r < `WB_NREGS; r++) begin
            @(negedge clk);
            rf_raddr = reg_idx_t'(r);
            #1;
            check_value($sformatf("rf_rdata[x%0d]", r), rf_rdata, shadow_regs[r]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verif/wb_assert.sv
`timescale 1ns/1ps

module wb_assert
    import wb_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input wb_result_t commit,
    input logic       mem_block,
    input logic       mul_block,
    input logic       div_block,
    input logic       mem_wen,
    input logic       div_wen,
    input logic       mul_wen,
    input pc_t        mem_pc,
    input pc_t        div_pc,
    input pc_t        mul_pc
);
    logic grant_mem;
    logic grant_div;
    logic grant_mul;

    // A source is granted when the commit carries its pc
    assign grant_mem = commit.wen && mem_wen && (commit.pc == mem_pc);
    assign grant_div = commit.wen && div_wen && (commit.pc == div_pc);
    assign grant_mul = commit.wen && mul_wen && (commit.pc == mul_pc);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant and block rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_grant_free: assert property (@(posedge clk) disable iff (rst)
        commit.wen |-> $onehot({grant_mem, grant_div, grant_mul})
            && !(grant_mem && mem_block) && !(grant_div && div_block)
            && !(grant_mul && mul_block))
        else $error("commit is not from exactly one unblocked source");

    a_mem_block_idle: assert property (@(posedge clk) disable iff (rst)
        mem_block |-> !commit.wen)
        else $error("commit while the memory source is blocked");

    a_reset_clear: assert property (@(posedge clk)
        $past(rst) |-> !mem_block && !mul_block && !div_block && !commit.wen)
        else $error("block or commit level high right after reset");

endmodule

bind wb_arbiter wb_assert u_assert (
    .clk(clk), .rst(rst), .commit(commit), .mem_block(mem_block),
    .mul_block(mul_block), .div_block(div_block), .mem_wen(mem_q.wen),
    .div_wen(div_q.wen), .mul_wen(mul_q.wen), .mem_pc(mem_q.pc),
    .div_pc(div_q.pc), .mul_pc(mul_q.pc)
);

// File: src/exec_backend_top.sv
`timescale 1ns/1ps

module exec_backend_top
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  issue_t     issue,
    input  logic       mem_stall,
    output logic       issue_ready,
    output wb_result_t commit,
    input  reg_idx_t   rf_raddr,
    output xword_t     rf_rdata
);
    logic       take;                     // Issue accepted this cycle
    logic       mem_busy;
    logic       div_idle;
    logic       mem_block;
    logic       mul_block;
    logic       div_block;
    logic       rd_valid;
    logic       rd_error;
    xword_t     rd_data;
    wb_result_t mem_res;
    wb_result_t mul_res;
    wb_result_t div_res;

    always_comb begin
        case (issue.op)
            OP_ALU, OP_LOAD: issue_ready = !mem_busy;
            OP_MUL:          issue_ready = !mul_block;
            default:         issue_ready = div_idle;
        endcase
    end

    assign take = issue_valid && issue_ready;

    mem_stage u_mem (
        .clk(clk), .rst(rst),
        .in_valid(take && (issue.op == OP_ALU || issue.op == OP_LOAD)),
        .in(issue), .stall(mem_stall), .block(mem_block), .busy(mem_busy),
        .result(mem_res), .rd_valid(rd_valid), .rd_data(rd_data), .rd_error(rd_error)
    );

    mul_pipe u_mul (
        .clk(clk), .rst(rst), .in_valid(take && issue.op == OP_MUL),
        .in(issue), .block(mul_block), .result(mul_res)
    );

    div_unit u_div (
        .clk(clk), .rst(rst), .in_valid(take && issue.op == OP_DIV),
        .in(issue), .block(div_block), .idle(div_idle), .result(div_res)
    );

    wb_arbiter u_arb (
        .clk(clk), .rst(rst), .mem_res(mem_res), .mul_res(mul_res), .div_res(div_res),
        .rd_valid(rd_valid), .rd_error(rd_error), .rd_data(rd_data), .commit(commit),
        .mem_block(mem_block), .mul_block(mul_block), .div_block(div_block)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .we(commit.wen), .waddr(commit.rd), .wdata(commit.data),
        .raddr(rf_raddr), .rdata(rf_rdata)
    );

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module reg_file
    import wb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_idx_t waddr,
    input  xword_t   wdata,
    input  reg_idx_t raddr,
    output xword_t   rdata
);
    xword_t regs [`WB_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// File: src/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  wb_result_t mem_res,
    input  wb_result_t mul_res,
    input  wb_result_t div_res,
    input  logic       rd_valid,
    input  logic       rd_error,
    input  xword_t     rd_data,
    output wb_result_t commit,
    output logic       mem_block,
    output logic       mul_block,
    output logic       div_block
);
    wb_result_t mem_q;
    wb_result_t mul_q;
    wb_result_t div_q;
    logic       mem_done;                 // Memory item commits now
    logic       mem_pend;                 // Load still waiting on response

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Source registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_q <= '0;
            mul_q <= '0;
            div_q <= '0;
        end else begin
            if (!mem_block) begin
                mem_q <= mem_res;
            end
            if (!mul_block) begin
                mul_q <= mul_res;
            end
            if (!div_block) begin
                div_q <= div_res;
            end
        end
    end

    assign mem_done = mem_q.wen && rd_valid;
    assign mem_pend = mem_q.wen && !rd_valid;

    // Memory, then divider, then multiplier
    assign mem_block = mem_pend;
    assign div_block = div_q.wen && (mem_done || mem_pend);
    assign mul_block = mul_q.wen && (div_q.wen || mem_done || mem_pend);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        commit = '0;
        if (mem_done) begin
            commit       = mem_q;
            commit.data  = rd_data;
            commit.error = mem_q.error || rd_error;
        end else if (div_q.wen && !mem_pend) begin
            commit = div_q;
        end else if (mul_q.wen && !div_q.wen && !mem_pend) begin
            commit = mul_q;
        end
    end

endmodule

// File: src/div_unit.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module div_unit
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  issue_t     in,
    input  logic       block,
    output logic       idle,
    output wb_result_t result
);
    localparam int CNT_W = $clog2(`WB_XLEN);

    div_state_t        state;
    logic [CNT_W-1:0]  count;
    xword_t            quot;              // Dividend shifts out, quotient in
    xword_t            divisor;
    xword_t            rem;
    logic [`WB_XLEN:0] rem_shift;
    logic [`WB_XLEN:0] diff;
    reg_idx_t          rd_q;
    pc_t               pc_q;

    assign rem_shift = {rem, quot[`WB_XLEN-1]};
    assign diff      = rem_shift - {1'b0, divisor};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Restoring division FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (in_valid) begin
                        quot    <= in.a;
                        divisor <= in.b;
                        rem     <= '0;
                        count   <= '0;
                        rd_q    <= in.rd;
                        pc_q    <= in.pc;
                        state   <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    if (!diff[`WB_XLEN]) begin   // Trial subtract fits
                        rem  <= diff[`WB_XLEN-1:0];
                        quot <= {quot[`WB_XLEN-2:0], 1'b1};
                    end else begin
                        rem  <= rem_shift[`WB_XLEN-1:0];
                        quot <= {quot[`WB_XLEN-2:0], 1'b0};
                    end
                    count <= count + 1'b1;
                    if (count == CNT_W'(`WB_XLEN - 1)) begin
                        state <= DIV_HOLD;
                    end
                end
                DIV_HOLD: begin
                    if (!block) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    assign idle = (state == DIV_IDLE);

    always_comb begin
        result.wen   = (state == DIV_HOLD);
        result.rd    = rd_q;
        result.data  = quot;              // Zero divisor leaves all ones
        result.pc    = pc_q;
        result.error = 1'b0;
    end

endmodule

// File: src/mul_pipe.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module mul_pipe
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  issue_t     in,
    input  logic       block,
    output wb_result_t result
);
    localparam int HALF = `WB_XLEN / 2;

    logic      s1_valid;
    xword_t    s1_a;
    xword_t    s1_b;
    reg_idx_t  s1_rd;
    pc_t       s1_pc;
    logic      s2_valid;
    xword_t    s2_lo;                     // a * b[low half]
    logic [HALF-1:0] s2_hi;               // a[low] * b[high], low half only
    reg_idx_t  s2_rd;
    pc_t       s2_pc;
    wb_result_t s3_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_q.wen <= 1'b0;
        end else if (!block) begin        // Whole pipe freezes on block
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
            s3_q.wen <= s2_valid;
        end

        if (!block) begin
            s1_a  <= in.a;
            s1_b  <= in.b;
            s1_rd <= in.rd;
            s1_pc <= in.pc;

            s2_lo <= s1_a * {{HALF{1'b0}}, s1_b[HALF-1:0]};
            s2_hi <= s1_a[HALF-1:0] * s1_b[`WB_XLEN-1:HALF];
            s2_rd <= s1_rd;
            s2_pc <= s1_pc;

            s3_q.data  <= s2_lo + {s2_hi, {HALF{1'b0}}};
            s3_q.rd    <= s2_rd;
            s3_q.pc    <= s2_pc;
            s3_q.error <= 1'b0;
        end
    end

    assign result = s3_q;

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module mem_stage
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  issue_t     in,
    input  logic       stall,
    input  logic       block,
    output logic       busy,
    output wb_result_t result,
    output logic       rd_valid,
    output xword_t     rd_data,
    output logic       rd_error
);
    localparam int IDX_W = $clog2(`WB_MEM_WORDS);

    xword_t           pattern_mem [`WB_MEM_WORDS];
    logic             item_valid;
    logic             presented;      // Arbiter holds its copy
    logic             is_load;
    xword_t           a_q;
    reg_idx_t         rd_q;
    pc_t              pc_q;
    logic [IDX_W-1:0] word_idx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pattern memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < `WB_MEM_WORDS; i++) begin : g_rom
        assign pattern_mem[i] = xword_t'(i) * {(`WB_XLEN/8){8'h01}};
    end

    assign word_idx = a_q[IDX_W+2:3];     // Byte address to word index

    always_ff @(posedge clk) begin
        if (rst) begin
            item_valid <= 1'b0;
            presented  <= 1'b0;
        end else if (item_valid) begin
            if (rd_valid) begin           // Committed this cycle
                item_valid <= 1'b0;
                presented  <= 1'b0;
            end else if (!block) begin
                presented <= 1'b1;
            end
        end else if (in_valid) begin
            item_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !item_valid) begin
            is_load <= (in.op == OP_LOAD);
            a_q     <= in.a;
            rd_q    <= in.rd;
            pc_q    <= in.pc;
        end
    end

    assign busy = item_valid;

    always_comb begin
        result.wen   = item_valid && !presented;   // Offered once
        result.rd    = rd_q;
        result.data  = a_q;
        result.pc    = pc_q;
        result.error = 1'b0;
    end

    // Response lines refer to the copy already held by the arbiter
    assign rd_valid = item_valid && presented && (!is_load || !stall);
    assign rd_data  = is_load ? pattern_mem[word_idx] : a_q;
    assign rd_error = rd_valid && is_load && (a_q[2:0] != 3'b000);

endmodule

// File: src/wb_pkg.sv
`include "wb_defines.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0] xword_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [`WB_XLEN-1:0] pc_t;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_MUL,
        OP_DIV
    } op_kind_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_HOLD
    } div_state_t;

    // Result handed from a unit to writeback, also the commit trace
    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xword_t   data;
        pc_t      pc;
        logic     error;
    } wb_result_t;

    typedef struct packed {
        op_kind_t op;
        xword_t   a;
        xword_t   b;
        reg_idx_t rd;
        pc_t      pc;
    } issue_t;

endpackage

// File: include/wb_defines.svh
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define WB_XLEN 64              // Data and address width
`define WB_NREGS 32             // Architectural registers

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unit sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define WB_MUL_STAGES 3         // Multiplier pipeline depth
`define WB_MEM_WORDS 256        // Pattern memory depth in words

`endif
